// ==== rv_pkg.sv ====
// RV32I core package with widths, instruction encodings and pipeline structs
package rv_pkg;

  // Data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  // Branch conditions, straight from funct3
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_t;

  // Access size from funct3, shared by loads and stores
  typedef enum logic [2:0] {
    size_b  = 3'b000,
    size_h  = 3'b001,
    size_w  = 3'b010,
    size_bu = 3'b100,
    size_hu = 3'b101
  } mem_size_t;

  typedef enum logic {asel_rs1, asel_pc} a_sel_t;
  typedef enum logic {bsel_rs2, bsel_imm} b_sel_t;
  typedef enum logic [1:0] {wsel_alu, wsel_load, wsel_pc4, wsel_imm} wb_sel_t;

  // Decoded control for one instruction
  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    word_t      imm;
    alu_op_t    alu_op;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    wb_sel_t    w_sel;
    logic       wen;
    logic       dren;
    logic       dwen;
    logic       branch;
    logic       jump;
    logic       jalr;
    mem_size_t  mem_size;
    branch_t    branch_type;
    logic       halt;
  } ctrl_t;

  // Fetch/execute pipeline register
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t pc4;
    word_t instr;
  } fetch_ex_t;

  localparam word_t reset_pc   = 32'h0000_0000;
  // ECALL encoding doubles as the halt instruction
  localparam word_t halt_instr = 32'h0000_0073;

endpackage

// ==== control_unit.sv ====
// Instruction decoder turning an RV32I word into the decoded control struct
module control_unit (
  input  rv_pkg::word_t instr,
  output rv_pkg::ctrl_t ctrl
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  alu_op_t    f3_op;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // Unknown encodings still cast, they fall to the default arm
  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  // funct7 bit 5 selects sub and sra
  assign alt    = instr[30];

  // Sign-extended immediates for every format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ALU operation from funct3, shared by register and immediate forms
  always_comb begin
    case (funct3)
      // Sub exists only in the register form
      3'b000:  f3_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = alt ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    // Defaults give a no-op
    ctrl             = '0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];
    ctrl.imm         = imm_i;
    ctrl.alu_op      = alu_add;
    ctrl.a_sel       = asel_rs1;
    ctrl.b_sel       = bsel_rs2;
    ctrl.w_sel       = wsel_alu;
    ctrl.mem_size    = mem_size_t'(funct3);
    ctrl.branch_type = branch_t'(funct3);

    case (opcode)
      op_reg: begin
        ctrl.alu_op = f3_op;
        ctrl.wen    = 1'b1;
      end
      op_imm: begin
        ctrl.alu_op = f3_op;
        ctrl.b_sel  = bsel_imm;
        ctrl.wen    = 1'b1;
      end
      op_load: begin
        // Address is rs1 plus imm
        ctrl.b_sel = bsel_imm;
        ctrl.w_sel = wsel_load;
        ctrl.dren  = 1'b1;
        ctrl.wen   = 1'b1;
      end
      op_store: begin
        ctrl.imm   = imm_s;
        ctrl.b_sel = bsel_imm;
        ctrl.dwen  = 1'b1;
      end
      op_branch: begin
        ctrl.imm    = imm_b;
        ctrl.branch = 1'b1;
      end
      op_jal: begin
        ctrl.imm   = imm_j;
        ctrl.jump  = 1'b1;
        ctrl.w_sel = wsel_pc4;
        ctrl.wen   = 1'b1;
      end
      op_jalr: begin
        ctrl.jump  = 1'b1;
        ctrl.jalr  = 1'b1;
        ctrl.w_sel = wsel_pc4;
        ctrl.wen   = 1'b1;
      end
      op_lui: begin
        ctrl.imm   = imm_u;
        ctrl.w_sel = wsel_imm;
        ctrl.wen   = 1'b1;
      end
      op_auipc: begin
        ctrl.imm   = imm_u;
        ctrl.a_sel = asel_pc;
        ctrl.b_sel = bsel_imm;
        ctrl.wen   = 1'b1;
      end
      op_system: begin
        // Only the exact ECALL word halts, the rest are no-ops
        ctrl.halt = (instr == halt_instr);
      end
      default: begin
      end
    endcase

    // Writes to x0 are dropped here
    ctrl.wen = ctrl.wen && (ctrl.rd != 5'd0);
  end

endmodule

// ==== reg_file.sv ====
// Integer register file, x1 to x31 with x0 reading as zero
module reg_file (
  input  logic          CLK,
  input  logic          arst_n,
  input  logic [4:0]    rs1,
  input  logic [4:0]    rs2,
  input  logic [4:0]    rd,
  input  logic          wen,
  input  rv_pkg::word_t w_data,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data
);
  import rv_pkg::*;

  // No storage for x0
  word_t regs [1:31];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= w_data;
    end
  end

  // Asynchronous reads
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== alu.sv ====
// ALU for arithmetic, logic, shift and compare, plus the branch condition
module alu (
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::word_t   port_a,
  input  rv_pkg::word_t   port_b,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::branch_t branch_type,
  output rv_pkg::word_t   port_out,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;

  // Only the low five bits shift
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:  port_out = port_a + port_b;
      alu_sub:  port_out = port_a - port_b;
      alu_sll:  port_out = port_a << shamt;
      alu_slt:  port_out = {31'd0, $signed(port_a) < $signed(port_b)};
      alu_sltu: port_out = {31'd0, port_a < port_b};
      alu_xor:  port_out = port_a ^ port_b;
      alu_srl:  port_out = port_a >> shamt;
      alu_sra:  port_out = $signed(port_a) >>> shamt;
      alu_or:   port_out = port_a | port_b;
      alu_and:  port_out = port_a & port_b;
      default:  port_out = '0;
    endcase
  end

  // Branch compare works on the register values, not the ALU operands
  always_comb begin
    case (branch_type)
      beq:     branch_taken = (rs1_data == rs2_data);
      bne:     branch_taken = (rs1_data != rs2_data);
      blt:     branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      bge:     branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      bltu:    branch_taken = (rs1_data < rs2_data);
      bgeu:    branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== fetch_stage.sv ====
// Fetch stage: program counter and Wishbone instruction master feeding the execute stage
module fetch_stage (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              ex_ready,
  input  logic              redirect,
  input  rv_pkg::word_t     redirect_pc,
  input  logic              halt,
  input  rv_pkg::word_t     i_dat_r,
  input  logic              i_ack,
  output rv_pkg::fetch_ex_t fe_reg,
  output logic              i_cyc,
  output logic              i_stb,
  output logic              i_we,
  output rv_pkg::word_t     i_adr
);
  import rv_pkg::*;

  // Drop means the cycle in flight was squashed and its data is thrown away
  typedef enum logic [1:0] {idle, busy, drop} fetch_state_t;

  fetch_state_t state;
  word_t        fetch_pc;
  word_t        next_pc;
  fetch_ex_t    hold;
  fetch_ex_t    fetched;
  logic         take;
  logic         stop;
  logic         fe_free;

  // Accepted data: a live cycle acked, not squashed by redirect or halt
  assign take    = (state == busy) && i_ack && !redirect && !halt;
  // Halt instruction sitting in the register stops new fetches early
  assign stop    = halt || (fe_reg.valid && (fe_reg.instr == halt_instr));
  assign fe_free = !fe_reg.valid || ex_ready;
  assign fetched = '{valid: 1'b1, pc: fetch_pc, pc4: fetch_pc + 32'd4, instr: i_dat_r};

  // Bus outputs come straight from the cycle state
  assign i_cyc = (state != idle);
  assign i_stb = i_cyc;
  assign i_we  = 1'b0;
  assign i_adr = fetch_pc;

  // Bus cycle FSM, address held stable until ack
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state    <= idle;
      fetch_pc <= reset_pc;
    end else begin
      case (state)
        idle: begin
          // No new fetch while the hold buffer is occupied
          if (!stop && !hold.valid) begin
            state    <= busy;
            fetch_pc <= redirect ? redirect_pc : next_pc;
          end
        end
        busy: begin
          if (i_ack) begin
            state <= idle;
          end else if (redirect) begin
            state <= drop;
          end
        end
        drop: begin
          if (i_ack) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Next pc, fetch/execute register and one-entry hold buffer
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      next_pc <= reset_pc;
      fe_reg  <= '0;
      hold    <= '0;
    end else if (redirect) begin
      // Squash everything fetched down the wrong path
      next_pc      <= redirect_pc;
      fe_reg.valid <= 1'b0;
      hold.valid   <= 1'b0;
    end else begin
      if (take) begin
        next_pc <= fetch_pc + 32'd4;
      end
      if (fe_free) begin
        // Buffered word goes first, otherwise the fresh one or a bubble
        if (hold.valid) begin
          fe_reg <= hold;
        end else if (take) begin
          fe_reg <= fetched;
        end else begin
          fe_reg.valid <= 1'b0;
        end
        hold.valid <= 1'b0;
      end else if (take) begin
        // Execute stalled, park the word
        hold <= fetched;
      end
    end
  end

endmodule

// ==== execute_stage.sv ====
// Execute stage: decode, ALU, branch resolution, Wishbone data master and write-back
module execute_stage (
  input  logic              CLK,
  input  logic              arst_n,
  input  rv_pkg::fetch_ex_t fe_reg,
  input  rv_pkg::word_t     d_dat_r,
  input  logic              d_ack,
  output logic              ex_ready,
  output logic              redirect,
  output rv_pkg::word_t     redirect_pc,
  output logic              d_cyc,
  output logic              d_stb,
  output logic              d_we,
  output rv_pkg::word_t     d_adr,
  output rv_pkg::word_t     d_dat_w,
  output logic [3:0]        d_sel,
  output logic              halt
);
  import rv_pkg::*;

  ctrl_t       ctrl;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       port_a;
  word_t       port_b;
  word_t       alu_out;
  word_t       load_data;
  word_t       w_data;
  logic        branch_taken;
  logic        active;
  logic        mem_op;
  logic        mem_done;
  logic        d_ack_q;
  logic        wen;
  logic [1:0]  byte_off;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  control_unit cu_i (
    .instr (fe_reg.instr),
    .ctrl  (ctrl)
  );

  reg_file rf_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wen      (wen),
    .w_data   (w_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .alu_op       (ctrl.alu_op),
    .port_a       (port_a),
    .port_b       (port_b),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .branch_type  (ctrl.branch_type),
    .port_out     (alu_out),
    .branch_taken (branch_taken)
  );

  // Nothing executes once halted
  assign active = fe_reg.valid && !halt;

  // Operand selection
  assign port_a = (ctrl.a_sel == asel_pc) ? fe_reg.pc : rs1_data;
  assign port_b = (ctrl.b_sel == bsel_imm) ? ctrl.imm : rs2_data;

  // Taken branch or any jump flushes the fetch register
  assign redirect    = active && (ctrl.jump || (ctrl.branch && branch_taken));
  // JALR clears bit 0 of rs1 plus imm
  assign redirect_pc = ctrl.jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : (fe_reg.pc + ctrl.imm);

  // Data bus, one idle cycle after each ack
  assign mem_op   = active && (ctrl.dren || ctrl.dwen);
  assign d_cyc    = mem_op && !d_ack_q;
  assign d_stb    = d_cyc;
  assign d_we     = ctrl.dwen;
  assign mem_done = d_cyc && d_ack;
  assign d_adr    = {alu_out[31:2], 2'b00};
  assign byte_off = alu_out[1:0];

  // Memory instructions wait for ack, all others retire at once
  assign ex_ready = !halt && (!mem_op || mem_done);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      d_ack_q <= 1'b0;
    end else begin
      d_ack_q <= mem_done;
    end
  end

  // Lane selects from size and offset
  always_comb begin
    case (ctrl.mem_size)
      size_b, size_bu: d_sel = 4'b0001 << byte_off;
      size_h, size_hu: d_sel = byte_off[1] ? 4'b1100 : 4'b0011;
      default:         d_sel = 4'b1111;
    endcase
  end

  // Store data copied to every lane
  always_comb begin
    case (ctrl.mem_size)
      size_b, size_bu: d_dat_w = {4{rs2_data[7:0]}};
      size_h, size_hu: d_dat_w = {2{rs2_data[15:0]}};
      default:         d_dat_w = rs2_data;
    endcase
  end

  // Pick the addressed lane and extend it
  assign load_byte = d_dat_r[{byte_off, 3'b000} +: 8];
  assign load_half = byte_off[1] ? d_dat_r[31:16] : d_dat_r[15:0];

  always_comb begin
    case (ctrl.mem_size)
      size_b:  load_data = {{24{load_byte[7]}}, load_byte};
      size_bu: load_data = {24'd0, load_byte};
      size_h:  load_data = {{16{load_half[15]}}, load_half};
      size_hu: load_data = {16'd0, load_half};
      default: load_data = d_dat_r;
    endcase
  end

  // Write-back source
  always_comb begin
    case (ctrl.w_sel)
      wsel_load: w_data = load_data;
      wsel_pc4:  w_data = fe_reg.pc4;
      wsel_imm:  w_data = ctrl.imm;
      default:   w_data = alu_out;
    endcase
  end

  // Loads write on the ack edge
  assign wen = ctrl.wen && active && (!ctrl.dren || mem_done);

  // Halt is sticky until reset
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      halt <= 1'b0;
    end else if (active && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== core_top.sv ====
// Two-stage RV32I core top with Wishbone instruction and data buses
module core_top (
  input  logic          CLK,
  input  logic          arst_n,
  // Instruction bus
  output logic          i_cyc,
  output logic          i_stb,
  output logic          i_we,
  output rv_pkg::word_t i_adr,
  input  rv_pkg::word_t i_dat_r,
  input  logic          i_ack,
  // Data bus
  output logic          d_cyc,
  output logic          d_stb,
  output logic          d_we,
  output rv_pkg::word_t d_adr,
  output logic [3:0]    d_sel,
  output rv_pkg::word_t d_dat_w,
  input  rv_pkg::word_t d_dat_r,
  input  logic          d_ack,
  output logic          halt
);
  import rv_pkg::*;

  fetch_ex_t fe_reg;
  logic      ex_ready;
  logic      redirect;
  word_t     redirect_pc;

  fetch_stage fetch_i (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .ex_ready    (ex_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt),
    .i_dat_r     (i_dat_r),
    .i_ack       (i_ack),
    .fe_reg      (fe_reg),
    .i_cyc       (i_cyc),
    .i_stb       (i_stb),
    .i_we        (i_we),
    .i_adr       (i_adr)
  );

  execute_stage execute_i (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .fe_reg      (fe_reg),
    .d_dat_r     (d_dat_r),
    .d_ack       (d_ack),
    .ex_ready    (ex_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .d_cyc       (d_cyc),
    .d_stb       (d_stb),
    .d_we        (d_we),
    .d_adr       (d_adr),
    .d_dat_w     (d_dat_w),
    .d_sel       (d_sel),
    .halt        (halt)
  );

endmodule

// ==== core_asserts.sv ====
// Bus protocol and halt checks bound into the core top
module core_asserts (
  input logic          CLK,
  input logic          arst_n,
  input logic          i_cyc,
  input logic          i_stb,
  input logic          i_we,
  input rv_pkg::word_t i_adr,
  input logic          i_ack,
  input logic          d_cyc,
  input logic          d_stb,
  input logic          d_we,
  input rv_pkg::word_t d_adr,
  input logic [3:0]    d_sel,
  input logic          d_ack,
  input logic          halt
);

  // Number of failed assertions
  int fail_count = 0;

  // Strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge CLK) disable iff (!arst_n)
    (i_stb -> i_cyc) && (d_stb -> d_cyc)) else begin
    $error("stb without cyc");
    fail_count++;
  end

  // Instruction bus is read only
  i_read_only: assert property (@(posedge CLK) disable iff (!arst_n)
    i_cyc |-> !i_we) else begin
    $error("write cycle on the instruction bus");
    fail_count++;
  end

  // Request held steady until ack
  i_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (i_stb && !i_ack) |=> (i_stb && $stable(i_adr))) else begin
    $error("i_adr moved before ack");
    fail_count++;
  end
  d_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (d_stb && !d_ack) |=> (d_stb && $stable(d_adr) && $stable(d_sel))) else begin
    $error("d_adr or d_sel moved before ack");
    fail_count++;
  end

  // Halt is sticky and stops new cycles, a fetch in flight may finish
  halt_sticky: assert property (@(posedge CLK) disable iff (!arst_n)
    halt |=> halt) else begin
    $error("halt dropped");
    fail_count++;
  end
  no_fetch_after_halt: assert property (@(posedge CLK) disable iff (!arst_n)
    (halt && !i_cyc) |=> !i_cyc) else begin
    $error("fetch started after halt");
    fail_count++;
  end
  no_data_after_halt: assert property (@(posedge CLK) disable iff (!arst_n)
    halt |-> !d_cyc) else begin
    $error("data cycle after halt");
    fail_count++;
  end

  store_sel: assert property (@(posedge CLK) disable iff (!arst_n)
    (d_cyc && d_we) |-> (d_sel != 4'b0000)) else begin
    $error("store with empty d_sel");
    fail_count++;
  end

endmodule

// ==== tb_core.sv ====
// Testbench for the two-stage RV32I core with Wishbone memory models and directed tests
module tb_core;
  import rv_pkg::*;

  logic        CLK;
  logic        arst_n;
  logic        i_cyc;
  logic        i_stb;
  logic        i_we;
  word_t       i_adr;
  word_t       i_dat_r;
  logic        i_ack;
  logic        d_cyc;
  logic        d_stb;
  logic        d_we;
  word_t       d_adr;
  logic [3:0]  d_sel;
  word_t       d_dat_w;
  word_t       d_dat_r;
  logic        d_ack;
  logic        halt;

  // Memory models, 64 words each, separate address spaces
  word_t       imem [0:63];
  word_t       dmem [0:63];
  word_t       exp_mem [0:63];
  // Store log entries hold {sel, adr}
  logic [35:0] store_log [$];
  int          i_wait;
  int          d_wait;
  logic        waits_on;
  word_t       prog_pc;
  int          errors;
  int          tests_run;
  int          tests_failed;

  core_top dut_i (.*);

  bind core_top core_asserts asserts_i (.*);

  always #10 CLK = ~CLK;

  // Instruction bus responder, acks a short delay after the edge
  always @(posedge CLK) begin
    #2;
    if (!arst_n || i_ack) begin
      i_ack  = 1'b0;
      i_wait = -1;
    end else if (i_cyc && i_stb) begin
      if (i_wait < 0)
        i_wait = waits_on ? $urandom_range(3, 0) : 0;
      if (i_wait == 0) begin
        i_dat_r = imem[i_adr[7:2]];
        i_ack   = 1'b1;
        i_wait  = -1;
      end else begin
        i_wait--;
      end
    end
  end

  // Data bus responder, stores write the selected lanes on ack
  always @(posedge CLK) begin
    #2;
    if (!arst_n || d_ack) begin
      d_ack  = 1'b0;
      d_wait = -1;
    end else if (d_cyc && d_stb) begin
      if (d_wait < 0)
        d_wait = waits_on ? $urandom_range(3, 0) : 0;
      if (d_wait == 0) begin
        if (d_we) begin
          for (int l = 0; l < 4; l++)
            if (d_sel[l])
              dmem[d_adr[7:2]][l*8 +: 8] = d_dat_w[l*8 +: 8];
          store_log.push_back({d_sel, d_adr});
        end else begin
          d_dat_r = dmem[d_adr[7:2]];
        end
        d_ack  = 1'b1;
        d_wait = -1;
      end else begin
        d_wait--;
      end
    end
  end

  // Instruction encoders for hand assembly
  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Fill word depends on the full word index
  function automatic word_t fill_word(int idx);
    return {4{8'(idx)}} ^ 32'hA5C3_5A3C;
  endfunction

  task automatic emit(word_t instr);
    imem[prog_pc[7:2]] = instr;
    prog_pc += 4;
  endtask

  task automatic store_word(logic [4:0] rs2, logic [11:0] off);
    emit(s_type(off, rs2, 5'd0, 3'b010));
  endtask

  // Hold reset, fill memories and open an empty program
  task automatic start_test();
    @(posedge CLK);
    #2 arst_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      // Default code is addi x0, x0, idx
      imem[i]    = i_type(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);
      dmem[i]    = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    store_log.delete();
    prog_pc = reset_pc;
  endtask

  // Release reset and wait for halt, bounded by 400 cycles
  task automatic run_core(string name);
    int cycles;
    cycles = 0;
    repeat (3) @(posedge CLK);
    #2 arst_n = 1'b1;
    while (!halt && cycles < 400) begin
      @(posedge CLK);
      cycles++;
    end
    repeat (4) @(posedge CLK);
    assert (halt) else begin
      $display("%s: core did not reach the halt instruction", name);
      errors++;
    end
  endtask

  task automatic check_mem(string name);
    for (int i = 0; i < 64; i++) begin
      assert (dmem[i] === exp_mem[i]) else begin
        $display("error %s: mem[%0d] expected %h actual %h", name, i, exp_mem[i], dmem[i]);
        errors++;
      end
    end
  endtask

  task automatic check_store_count(string name, int expected);
    assert (store_log.size() == expected) else begin
      $display("error %s: store count expected %0d actual %0d", name, expected,
               store_log.size());
      errors++;
    end
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  // Register and immediate ALU program, results stored as words from address 0
  task automatic alu_program();
    word_t a;
    word_t b;
    word_t c;
    word_t auipc_pc;
    a = 32'h0000_0123;
    b = 32'hFFFF_FFFB;
    c = 32'h8765_4000;
    emit(i_type(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(i_type(12'hFFB, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(u_type(20'h87654, 5'd3, 7'b0110111));
    emit(i_type(12'd4, 5'd0, 3'b000, 5'd4, 7'b0010011));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    store_word(5'd5, 12'd0);
    emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
    store_word(5'd5, 12'd4);
    emit(r_type(7'h00, 5'd4, 5'd1, 3'b001, 5'd5));
    store_word(5'd5, 12'd8);
    emit(r_type(7'h00, 5'd4, 5'd3, 3'b101, 5'd5));
    store_word(5'd5, 12'd12);
    emit(r_type(7'h20, 5'd4, 5'd3, 3'b101, 5'd5));
    store_word(5'd5, 12'd16);
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
    store_word(5'd5, 12'd20);
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5));
    store_word(5'd5, 12'd24);
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
    store_word(5'd5, 12'd28);
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd5));
    store_word(5'd5, 12'd32);
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
    store_word(5'd5, 12'd36);
    // srai x5, x3, 8
    emit(i_type({7'h20, 5'd8}, 5'd3, 3'b101, 5'd5, 7'b0010011));
    store_word(5'd5, 12'd40);
    auipc_pc = prog_pc;
    emit(u_type(20'h00001, 5'd5, 7'b0010111));
    store_word(5'd5, 12'd44);
    emit(halt_instr);
    exp_mem[0]  = a + b;
    exp_mem[1]  = a - b;
    exp_mem[2]  = a << 4;
    exp_mem[3]  = c >> 4;
    exp_mem[4]  = word_t'($signed(c) >>> 4);
    exp_mem[5]  = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    exp_mem[6]  = (b < a) ? 32'd1 : 32'd0;
    exp_mem[7]  = a ^ b;
    exp_mem[8]  = a | b;
    exp_mem[9]  = a & b;
    exp_mem[10] = word_t'($signed(c) >>> 8);
    exp_mem[11] = auipc_pc + 32'h0000_1000;
  endtask

  task automatic test_alu(string name, logic waits);
    int err_before;
    err_before = errors;
    waits_on = waits;
    start_test();
    alu_program();
    run_core(name);
    check_mem(name);
    check_store_count(name, 12);
    finish_test(name, err_before);
  endtask

  task automatic test_stores();
    int          err_before;
    logic [3:0]  sels [6];
    word_t       adrs [6];
    err_before = errors;
    waits_on = 1'b0;
    sels = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    adrs = '{32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14};
    start_test();
    emit(u_type(20'h11223, 5'd1, 7'b0110111));
    emit(i_type(12'h344, 5'd1, 3'b000, 5'd1, 7'b0010011));
    // SB at byte offset k of word k
    for (int k = 0; k < 4; k++) begin
      emit(s_type(12'(k * 5), 5'd1, 5'd0, 3'b000));
      exp_mem[k][k*8 +: 8] = 8'h44;
    end
    emit(s_type(12'h010, 5'd1, 5'd0, 3'b001));
    emit(s_type(12'h016, 5'd1, 5'd0, 3'b001));
    emit(halt_instr);
    exp_mem[4][15:0]  = 16'h3344;
    exp_mem[5][31:16] = 16'h3344;
    run_core("stores");
    check_mem("stores");
    check_store_count("stores", 6);
    for (int k = 0; k < 6 && k < store_log.size(); k++) begin
      assert (store_log[k] == {sels[k], adrs[k]}) else begin
        $display("error stores: log[%0d] expected %h actual %h", k, {sels[k], adrs[k]},
                 store_log[k]);
        errors++;
      end
    end
    finish_test("stores", err_before);
  endtask

  task automatic test_loads();
    int          err_before;
    word_t       k;
    logic [2:0]  f3s [10];
    logic [11:0] offs [10];
    err_before = errors;
    waits_on = 1'b0;
    k = 32'h8C7F_E135;
    f3s  = '{3'b000, 3'b000, 3'b100, 3'b000, 3'b100, 3'b001, 3'b101, 3'b001, 3'b101, 3'b010};
    offs = '{12'h40, 12'h41, 12'h41, 12'h43, 12'h42, 12'h40, 12'h40, 12'h42, 12'h42, 12'h40};
    start_test();
    dmem[16]    = k;
    exp_mem[16] = k;
    for (int n = 0; n < 10; n++) begin
      emit(i_type(offs[n], 5'd0, f3s[n], 5'd5, 7'b0000011));
      store_word(5'd5, 12'(n * 4));
    end
    emit(halt_instr);
    exp_mem[0] = {24'd0, k[7:0]};
    exp_mem[1] = {{24{k[15]}}, k[15:8]};
    exp_mem[2] = {24'd0, k[15:8]};
    exp_mem[3] = {{24{k[31]}}, k[31:24]};
    exp_mem[4] = {24'd0, k[23:16]};
    exp_mem[5] = {{16{k[15]}}, k[15:0]};
    exp_mem[6] = {16'd0, k[15:0]};
    exp_mem[7] = {{16{k[31]}}, k[31:16]};
    exp_mem[8] = {16'd0, k[31:16]};
    exp_mem[9] = k;
    run_core("loads");
    check_mem("loads");
    check_store_count("loads", 10);
    finish_test("loads", err_before);
  endtask

  // Each branch skips the store after it when taken
  task automatic test_branches();
    int          err_before;
    word_t       jal_pc;
    word_t       jalr_pc;
    logic [2:0]  f3s [12];
    logic [4:0]  r1s [12];
    logic [4:0]  r2s [12];
    logic        taken [12];
    err_before = errors;
    waits_on = 1'b0;
    // x1 = 5, x2 = -3, x3 = 5
    f3s   = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
    r1s   = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    r2s   = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd1, 5'd2, 5'd3, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    taken = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    start_test();
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(i_type(12'hFFD, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(i_type(12'h777, 5'd0, 3'b000, 5'd7, 7'b0010011));
    for (int n = 0; n < 12; n++) begin
      emit(b_type(13'd8, r2s[n], r1s[n], f3s[n]));
      store_word(5'd7, 12'(n * 4));
      if (!taken[n])
        exp_mem[n] = 32'h0000_0777;
    end
    jal_pc = prog_pc;
    emit(j_type(21'd8, 5'd10));
    store_word(5'd7, 12'd48);
    store_word(5'd10, 12'd52);
    jalr_pc = prog_pc;
    emit(u_type(20'h0, 5'd11, 7'b0010111));
    emit(i_type(12'd16, 5'd11, 3'b000, 5'd12, 7'b1100111));
    store_word(5'd7, 12'd56);
    store_word(5'd7, 12'd60);
    store_word(5'd12, 12'd64);
    emit(halt_instr);
    exp_mem[13] = jal_pc + 32'd4;
    exp_mem[16] = jalr_pc + 32'd8;
    run_core("branches");
    check_mem("branches");
    check_store_count("branches", 8);
    finish_test("branches", err_before);
  endtask

  // Watchdog sized for five tests of 400 cycles each
  initial begin
    #(5 * 400 * 20);
    $display("timeout: the run did not finish in the allowed time");
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h5416_d8dc));
    CLK          = 1'b0;
    arst_n       = 1'b0;
    i_dat_r      = '0;
    i_ack        = 1'b0;
    d_dat_r      = '0;
    d_ack        = 1'b0;
    i_wait       = -1;
    d_wait       = -1;
    waits_on     = 1'b0;
    prog_pc      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_alu("alu_ops", 1'b0);
    test_stores();
    test_loads();
    test_branches();
    test_alu("wait_states", 1'b1);
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
             tests_failed, errors, dut_i.asserts_i.fail_count);
    if (tests_failed == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
rv_pkg.sv
control_unit.sv
reg_file.sv
alu.sv
fetch_stage.sv
execute_stage.sv
core_top.sv
core_asserts.sv
tb_core.sv
